//--- logic/vec_pkg.sv
`default_nettype none

package vec_pkg;

    // ------------------------------
    // global sizes
    // ------------------------------

    // register file depth in vectors
    localparam int NUM_VREGS  = 32;
    // scalar and memory address width
    localparam int XLEN       = 32;
    // fixed element width, no sew support
    localparam int ELEM_W     = 64;
    // unit stride step between elements
    localparam int ELEM_BYTES = ELEM_W / 8;
    localparam int REG_IDX_W  = 5;

    // ------------------------------
    // instruction fields
    // ------------------------------

    localparam int OPC_LSB = 0;
    localparam int OPC_MSB = 3;
    localparam int VD_LSB  = 7;
    localparam int VD_MSB  = 11;
    localparam int VS1_LSB = 15;
    localparam int VS1_MSB = 19;
    localparam int VS2_LSB = 20;
    localparam int VS2_MSB = 24;

    // opcode encodings, anything else is a no-op
    typedef enum logic [3:0] {
        op_setvl = 4'h0,
        op_load  = 4'h1,
        op_store = 4'h2,
        op_add   = 4'h3,
        op_sub   = 4'h4,
        op_and   = 4'h5,
        op_or    = 4'h6,
        op_xor   = 4'h7
    } vec_op_e;

    // sequencer fsm
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_run   = 2'd1,
        st_drain = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

//--- logic/vec_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module vec_sequencer #(
    parameter int VLMAX = 8,
    localparam int VL_W = $clog2(VLMAX + 1)
) (
    input  logic                          clk_r,
    input  logic                          reset,
    input  logic [vec_pkg::XLEN-1:0]      insn,
    input  logic [vec_pkg::XLEN-1:0]      rs1,
    input  logic                          insn_valid,
    input  logic                          exec_done,
    output logic                          insn_ready,
    output vec_pkg::vec_op_e              op,
    output logic [vec_pkg::REG_IDX_W-1:0] vd,
    output logic [vec_pkg::REG_IDX_W-1:0] vs1,
    output logic [vec_pkg::REG_IDX_W-1:0] vs2,
    output logic                          start,
    output logic [VL_W-1:0]               vl,
    output logic [vec_pkg::XLEN-1:0]      base_addr
);

    import vec_pkg::*;

    seq_state_e      state;
    vec_op_e         dec_op;
    logic            accept;
    logic            is_vec_op;
    logic [VL_W-1:0] vl_req;

    // ------------------------------
    // decode
    // ------------------------------

    // one instruction at a time, ready only when idle
    assign insn_ready = (state == st_idle);
    assign accept     = insn_valid & insn_ready;

    assign dec_op = vec_op_e'(insn[OPC_MSB:OPC_LSB]);

    // ops that walk the element stream
    assign is_vec_op = dec_op inside {op_load, op_store, op_add, op_sub,
                                      op_and, op_or, op_xor};

    // requested length clamped to vlmax
    assign vl_req = (rs1 > XLEN'(VLMAX)) ? VL_W'(VLMAX) : VL_W'(rs1);

    // operand fields, captured on accept and held while busy
    always_ff @(posedge clk_r) begin
        if (accept) begin
            op        <= dec_op;
            vd        <= insn[VD_MSB:VD_LSB];
            vs1       <= insn[VS1_MSB:VS1_LSB];
            vs2       <= insn[VS2_MSB:VS2_LSB];
            // memory base for load/store
            base_addr <= rs1;
        end
    end

    // ------------------------------
    // busy fsm and vl register
    // ------------------------------

    always_ff @(posedge clk_r) begin
        if (reset) begin
            state <= st_idle;
            start <= 1'b0;
            vl    <= VL_W'(VLMAX);
        end else begin
            // start is a single cycle pulse
            start <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (is_vec_op) begin
                            state <= st_run;
                            // empty vector, no element activity at all
                            start <= (vl != '0);
                        end else begin
                            // vsetvl and illegal ops finish in one extra cycle
                            state <= st_drain;
                            if (dec_op == op_setvl) begin
                                vl <= vl_req;
                            end
                        end
                    end
                end
                st_run: begin
                    // exec pulses done on the final writeback or store
                    if (exec_done) begin
                        state <= st_idle;
                    end else if (vl == '0) begin
                        state <= st_drain;
                    end
                end
                st_drain: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ------------------------------
    // checks
    // ------------------------------

    // start only right after leaving idle
    assert property (@(posedge clk_r) disable iff (reset)
        start |-> $past(state) == st_idle)
        else $error("start pulsed outside idle");

    // done from exec must belong to a running op
    assert property (@(posedge clk_r) disable iff (reset)
        exec_done |-> state == st_run)
        else $error("exec_done while sequencer not running");

endmodule

`default_nettype wire

//--- logic/vec_agu.sv
`timescale 1ns/1ns
`default_nettype none

module vec_agu #(
    parameter int VLMAX = 8,
    localparam int VL_W  = $clog2(VLMAX + 1),
    localparam int IDX_W = (VLMAX > 1) ? $clog2(VLMAX) : 1
) (
    input  logic                     clk_r,
    input  logic                     reset,
    input  logic                     start,
    input  logic [VL_W-1:0]          vl,
    input  logic [vec_pkg::XLEN-1:0] base_addr,
    output logic                     elem_valid,
    output logic [IDX_W-1:0]         elem_idx,
    output logic                     elem_last,
    output logic [vec_pkg::XLEN-1:0] elem_addr
);

    import vec_pkg::*;

    // ------------------------------
    // element counter
    // ------------------------------

    // one element per cycle from start until last
    always_ff @(posedge clk_r) begin
        if (reset) begin
            elem_valid <= 1'b0;
            elem_idx   <= '0;
        end else if (start) begin
            elem_valid <= 1'b1;
            elem_idx   <= '0;
        end else if (elem_valid) begin
            if (elem_last) begin
                elem_valid <= 1'b0;
            end else begin
                elem_idx <= elem_idx + IDX_W'(1);
            end
        end
    end

    // vl is held by the sequencer for the whole op
    assign elem_last = elem_valid && (VL_W'(elem_idx) == vl - VL_W'(1));

    // unit stride, base plus idx * 8
    assign elem_addr = base_addr + XLEN'(elem_idx) * XLEN'(ELEM_BYTES);

    // ------------------------------
    // checks
    // ------------------------------

    // vl from the sequencer must stay clamped, so the count never steps to vlmax
    assert property (@(posedge clk_r) disable iff (reset)
        elem_valid && !elem_last |-> int'(elem_idx) + 1 < VLMAX)
        else $error("element index reached vlmax");

    // no new op while the stream is still running
    assert property (@(posedge clk_r) disable iff (reset)
        start |-> !elem_valid)
        else $error("start while element stream busy");

endmodule

`default_nettype wire

//--- logic/vec_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module vec_regfile #(
    parameter int VLMAX = 8,
    localparam int IDX_W = (VLMAX > 1) ? $clog2(VLMAX) : 1
) (
    input  logic                          clk_r,
    // two read ports share the element index
    input  logic [vec_pkg::REG_IDX_W-1:0] rd_reg_a,
    input  logic [vec_pkg::REG_IDX_W-1:0] rd_reg_b,
    input  logic [IDX_W-1:0]              rd_idx,
    // write port from exec
    input  logic                          wr_en,
    input  logic [vec_pkg::REG_IDX_W-1:0] wr_reg,
    input  logic [IDX_W-1:0]              wr_idx,
    input  logic [vec_pkg::ELEM_W-1:0]    wr_data,
    output logic [vec_pkg::ELEM_W-1:0]    rd_data_a,
    output logic [vec_pkg::ELEM_W-1:0]    rd_data_b
);

    import vec_pkg::*;

    // ------------------------------
    // storage
    // ------------------------------

    // one row per vector register, vlmax elements each
    logic [ELEM_W-1:0] mem [NUM_VREGS][VLMAX];

    // read first on a same cycle write
    always_ff @(posedge clk_r) begin
        rd_data_a <= mem[rd_reg_a][rd_idx];
        rd_data_b <= mem[rd_reg_b][rd_idx];
        if (wr_en) begin
            mem[wr_reg][wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/vec_exec.sv
`timescale 1ns/1ns
`default_nettype none

module vec_exec #(
    parameter int VLMAX = 8,
    localparam int IDX_W = (VLMAX > 1) ? $clog2(VLMAX) : 1
) (
    input  logic                          clk_r,
    input  logic                          reset,
    input  vec_pkg::vec_op_e              op,
    input  logic [vec_pkg::REG_IDX_W-1:0] vd,
    // element stream straight from the agu
    input  logic                          elem_valid,
    input  logic [IDX_W-1:0]              elem_idx,
    input  logic                          elem_last,
    input  logic [vec_pkg::XLEN-1:0]      elem_addr,
    input  logic [vec_pkg::ELEM_W-1:0]    rd_data_a,
    input  logic [vec_pkg::ELEM_W-1:0]    rd_data_b,
    input  logic [vec_pkg::ELEM_W-1:0]    mem_rd_data,
    output logic                          wr_en,
    output logic [vec_pkg::REG_IDX_W-1:0] wr_reg,
    output logic [IDX_W-1:0]              wr_idx,
    output logic [vec_pkg::ELEM_W-1:0]    wr_data,
    output logic [vec_pkg::XLEN-1:0]      mem_wr_addr,
    output logic [vec_pkg::ELEM_W-1:0]    mem_wr_data,
    output logic                          mem_wr_en,
    output logic                          exec_done
);

    import vec_pkg::*;

    logic             s1_valid;
    logic             s1_last;
    logic [IDX_W-1:0] s1_idx;
    logic [XLEN-1:0]  s1_addr;
    logic             is_alu;

    // ------------------------------
    // align with read data
    // ------------------------------

    // regfile and load data both lag the agu by one cycle
    always_ff @(posedge clk_r) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= elem_valid;
        end
    end

    always_ff @(posedge clk_r) begin
        s1_last <= elem_last;
        s1_idx  <= elem_idx;
        s1_addr <= elem_addr;
    end

    // ------------------------------
    // alu and load mux
    // ------------------------------

    assign is_alu = op inside {op_add, op_sub, op_and, op_or, op_xor};

    // source a op source b, load data otherwise
    always_comb begin
        case (op)
            op_add:  wr_data = rd_data_a + rd_data_b;
            op_sub:  wr_data = rd_data_a - rd_data_b;
            op_and:  wr_data = rd_data_a & rd_data_b;
            op_or:   wr_data = rd_data_a | rd_data_b;
            op_xor:  wr_data = rd_data_a ^ rd_data_b;
            default: wr_data = mem_rd_data;
        endcase
    end

    // regfile write, taken on the next edge
    assign wr_en  = s1_valid & (is_alu | (op == op_load));
    assign wr_reg = vd;
    assign wr_idx = s1_idx;

    // store drives port a straight to memory
    assign mem_wr_en   = s1_valid & (op == op_store);
    assign mem_wr_addr = s1_addr;
    assign mem_wr_data = rd_data_a;

    // final element done
    assign exec_done = s1_valid & s1_last;

    // ------------------------------
    // checks
    // ------------------------------

    assert property (@(posedge clk_r) disable iff (reset)
        !(wr_en && mem_wr_en))
        else $error("regfile write and memory store in the same cycle");

    // sequencer holds the opcode while elements drain
    assert property (@(posedge clk_r) disable iff (reset)
        s1_valid |-> $stable(op))
        else $error("opcode changed with elements in flight");

endmodule

`default_nettype wire

//--- logic/vec_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module vec_unit_top #(
    parameter int VLMAX = 8
) (
    input  logic                       clk_r,
    input  logic                       reset,
    // instruction port
    input  logic [vec_pkg::XLEN-1:0]   insn,
    input  logic [vec_pkg::XLEN-1:0]   rs1,
    input  logic                       insn_valid,
    output logic                       insn_ready,
    // load side, fixed one cycle latency
    output logic [vec_pkg::XLEN-1:0]   mem_rd_addr,
    input  logic [vec_pkg::ELEM_W-1:0] mem_rd_data,
    // store side, always accepted
    output logic [vec_pkg::XLEN-1:0]   mem_wr_addr,
    output logic [vec_pkg::ELEM_W-1:0] mem_wr_data,
    output logic                       mem_wr_en
);

    import vec_pkg::*;

    localparam int VL_W  = $clog2(VLMAX + 1);
    localparam int IDX_W = (VLMAX > 1) ? $clog2(VLMAX) : 1;

    // sequencer outputs
    vec_op_e              op;
    logic [REG_IDX_W-1:0] vd;
    logic [REG_IDX_W-1:0] vs1;
    logic [REG_IDX_W-1:0] vs2;
    logic                 start;
    logic [VL_W-1:0]      vl;
    logic [XLEN-1:0]      base_addr;

    // agu stream
    logic                 elem_valid;
    logic [IDX_W-1:0]     elem_idx;
    logic                 elem_last;

    // regfile traffic
    logic [ELEM_W-1:0]    rd_data_a;
    logic [ELEM_W-1:0]    rd_data_b;
    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_reg;
    logic [IDX_W-1:0]     wr_idx;
    logic [ELEM_W-1:0]    wr_data;
    logic                 exec_done;

    // ------------------------------
    // blocks
    // ------------------------------

    vec_sequencer #(.VLMAX(VLMAX)) i_seq (
        .clk_r      (clk_r),
        .reset      (reset),
        .insn       (insn),
        .rs1        (rs1),
        .insn_valid (insn_valid),
        .exec_done  (exec_done),
        .insn_ready (insn_ready),
        .op         (op),
        .vd         (vd),
        .vs1        (vs1),
        .vs2        (vs2),
        .start      (start),
        .vl         (vl),
        .base_addr  (base_addr)
    );

    // element address doubles as the load address
    vec_agu #(.VLMAX(VLMAX)) i_agu (
        .clk_r      (clk_r),
        .reset      (reset),
        .start      (start),
        .vl         (vl),
        .base_addr  (base_addr),
        .elem_valid (elem_valid),
        .elem_idx   (elem_idx),
        .elem_last  (elem_last),
        .elem_addr  (mem_rd_addr)
    );

    // port a is vs1 for every op, store source included
    vec_regfile #(.VLMAX(VLMAX)) i_rf (
        .clk_r     (clk_r),
        .rd_reg_a  (vs1),
        .rd_reg_b  (vs2),
        .rd_idx    (elem_idx),
        .wr_en     (wr_en),
        .wr_reg    (wr_reg),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    vec_exec #(.VLMAX(VLMAX)) i_exec (
        .clk_r       (clk_r),
        .reset       (reset),
        .op          (op),
        .vd          (vd),
        .elem_valid  (elem_valid),
        .elem_idx    (elem_idx),
        .elem_last   (elem_last),
        .elem_addr   (mem_rd_addr),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .mem_rd_data (mem_rd_data),
        .wr_en       (wr_en),
        .wr_reg      (wr_reg),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .mem_wr_en   (mem_wr_en),
        .exec_done   (exec_done)
    );

endmodule

`default_nettype wire

//--- tests/tb_vec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vec_unit;

    import vec_pkg::*;

    localparam int VLMAX      = 8;
    localparam int CLK_PERIOD = 100;
    // upper bound on instructions issued over all tests
    localparam int NUM_INSN   = 40;
    localparam int TIMEOUT_NS = (10 + NUM_INSN * (VLMAX + 5) + 100) * CLK_PERIOD;
    localparam int WAIT_LIMIT = 4 * VLMAX + 20;

    logic              clk_r;
    logic              reset;
    logic [XLEN-1:0]   insn;
    logic [XLEN-1:0]   rs1;
    logic              insn_valid;
    logic              insn_ready;
    logic [XLEN-1:0]   mem_rd_addr;
    logic [ELEM_W-1:0] mem_rd_data = '0;
    logic [XLEN-1:0]   mem_wr_addr;
    logic [ELEM_W-1:0] mem_wr_data;
    logic              mem_wr_en;

    // load memory, observed stores and reference register file
    logic [ELEM_W-1:0] mem_model [logic [XLEN-1:0]];
    logic [ELEM_W-1:0] store_mem [logic [XLEN-1:0]];
    logic [ELEM_W-1:0] vreg_model [NUM_VREGS][VLMAX];
    logic [XLEN-1:0]   rd_addr_q = '0;
    // address window a store may hit
    logic [XLEN-1:0]   win_lo = '0;
    logic [XLEN-1:0]   win_hi = '0;

    integer seed           = 32'h1790;
    int     vl_cur;
    int     store_count    = 0;
    int     accept_count   = 0;
    int     monitor_errors = 0;
    int     value_errors;
    int     other_errors;
    string  cur_test;

    vec_unit_top #(.VLMAX(VLMAX)) i_dut (
        .clk_r       (clk_r),
        .reset       (reset),
        .insn        (insn),
        .rs1         (rs1),
        .insn_valid  (insn_valid),
        .insn_ready  (insn_ready),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .mem_wr_en   (mem_wr_en)
    );

    initial begin
        clk_r = 1'b0;
        forever #(CLK_PERIOD / 2) clk_r = ~clk_r;
    end

    // ------------------------------
    // memory model and monitors
    // ------------------------------

    // untouched locations read back a pattern of their own address
    function automatic logic [ELEM_W-1:0] fill_word(input logic [XLEN-1:0] addr);
        return {~addr, addr};
    endfunction

    function automatic logic [ELEM_W-1:0] read_mem(input logic [XLEN-1:0] addr);
        if (mem_model.exists(addr)) begin
            return mem_model[addr];
        end
        return fill_word(addr);
    endfunction

    always @(posedge clk_r) begin
        rd_addr_q <= mem_rd_addr;
    end

    // load data one cycle after its address
    always @(negedge clk_r) begin
        mem_rd_data <= read_mem(rd_addr_q);
    end

    always @(posedge clk_r) begin
        if (!reset && insn_valid && insn_ready) begin
            accept_count <= accept_count + 1;
        end
        if (!reset && mem_wr_en) begin
            store_mem[mem_wr_addr] = mem_wr_data;
            store_count <= store_count + 1;
            assert (mem_wr_addr >= win_lo && mem_wr_addr < win_hi) else begin
                $display("store to %h outside the expected range %h..%h",
                         mem_wr_addr, win_lo, win_hi);
                monitor_errors <= monitor_errors + 1;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, tests did not finish", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic logic [XLEN-1:0] make_insn(input vec_op_e op, input int vd,
                                                  input int vs1, input int vs2);
        logic [XLEN-1:0] word;
        word        = '0;
        word[3:0]   = op;
        word[11:7]  = 5'(vd);
        word[19:15] = 5'(vs1);
        word[24:20] = 5'(vs2);
        return word;
    endfunction

    function automatic logic [ELEM_W-1:0] alu_model(input vec_op_e op,
                                                    input logic [ELEM_W-1:0] a,
                                                    input logic [ELEM_W-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            default: return a ^ b;
        endcase
    endfunction

    // edges from accept until ready is seen high again
    function automatic int expected_edges(input vec_op_e op);
        if (op == op_setvl) begin
            return 1;
        end
        if (vl_cur == 0) begin
            return 2;
        end
        return vl_cur + 2;
    endfunction

    task automatic apply_model(input vec_op_e op, input int vd, input int vs1,
                               input int vs2, input logic [XLEN-1:0] scalar);
        if (op == op_setvl) begin
            vl_cur = (scalar > VLMAX) ? VLMAX : int'(scalar);
        end else if (op == op_load) begin
            for (int i = 0; i < vl_cur; i++) begin
                vreg_model[vd][i] = read_mem(scalar + XLEN'(i * ELEM_BYTES));
            end
        end else if (op != op_store) begin
            for (int i = 0; i < vl_cur; i++) begin
                vreg_model[vd][i] = alu_model(op, vreg_model[vs1][i], vreg_model[vs2][i]);
            end
        end
    endtask

    task automatic check_value(input string what, input logic [ELEM_W-1:0] expected,
                               input logic [ELEM_W-1:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic fill_random(input logic [XLEN-1:0] base);
        for (int i = 0; i < VLMAX; i++) begin
            mem_model[base + XLEN'(i * ELEM_BYTES)] = {$random(seed), $random(seed)};
        end
    endtask

    // ------------------------------
    // instruction driver
    // ------------------------------

    // called on a falling edge with the dut idle
    task automatic issue(input vec_op_e op, input int vd, input int vs1, input int vs2,
                         input logic [XLEN-1:0] scalar);
        int edges;
        int exp_edges;
        exp_edges = expected_edges(op);
        win_lo    = scalar;
        win_hi    = (op == op_store) ? scalar + XLEN'(vl_cur * ELEM_BYTES) : scalar;
        assert (insn_ready === 1'b1) else begin
            $display("%s: insn_ready low before a new instruction", cur_test);
            other_errors++;
        end
        insn       = make_insn(op, vd, vs1, vs2);
        rs1        = scalar;
        insn_valid = 1'b1;
        @(posedge clk_r);
        @(negedge clk_r);
        insn_valid = 1'b0;
        edges      = 0;
        while (!insn_ready && edges < WAIT_LIMIT) begin
            @(negedge clk_r);
            edges++;
        end
        assert (insn_ready === 1'b1) else begin
            $display("%s: insn_ready never came back after %s", cur_test, op.name());
            other_errors++;
        end
        check_value("cycles to ready", 64'(exp_edges), 64'(edges));
        apply_model(op, vd, vs1, vs2, scalar);
    endtask

    task automatic check_store(input int vs, input logic [XLEN-1:0] base, input int count0);
        logic [XLEN-1:0] addr;
        check_value("store count", 64'(vl_cur), 64'(store_count - count0));
        for (int i = 0; i < vl_cur; i++) begin
            addr = base + XLEN'(i * ELEM_BYTES);
            assert (store_mem.exists(addr)) else begin
                $display("%s: no store seen at address %h", cur_test, addr);
                other_errors++;
            end
            check_value($sformatf("element %0d", i), vreg_model[vs][i], store_mem[addr]);
        end
        // first element past vl must not be written
        if (vl_cur < VLMAX) begin
            addr = base + XLEN'(vl_cur * ELEM_BYTES);
            assert (!store_mem.exists(addr)) else begin
                $display("%s: store past vl at address %h", cur_test, addr);
                other_errors++;
            end
        end
    endtask

    task automatic load_fresh(input int vd, input logic [XLEN-1:0] base);
        fill_random(base);
        issue(op_load, vd, 0, 0, base);
    endtask

    task automatic store_and_check(input int vs, input logic [XLEN-1:0] base);
        int count0;
        count0 = store_count;
        issue(op_store, 0, vs, 0, base);
        check_store(vs, base, count0);
    endtask

    // ------------------------------
    // tests
    // ------------------------------

    task automatic test_reset();
        cur_test = "reset";
        assert (insn_ready === 1'b1) else begin
            $display("insn_ready not high after reset");
            other_errors++;
        end
        assert (mem_wr_en === 1'b0) else begin
            $display("mem_wr_en not low after reset");
            other_errors++;
        end
    endtask

    // runs at the reset value of vl
    task automatic test_round_trip();
        cur_test = "round_trip";
        load_fresh(1, 32'h1000);
        store_and_check(1, 32'h2000);
    endtask

    task automatic test_alu();
        vec_op_e ops [5];
        ops = '{op_add, op_sub, op_and, op_or, op_xor};
        cur_test = "alu";
        load_fresh(2, 32'h3000);
        load_fresh(3, 32'h3100);
        for (int k = 0; k < 5; k++) begin
            cur_test = $sformatf("alu_%s", ops[k].name());
            issue(ops[k], 4, 2, 3, 32'h0);
            store_and_check(4, 32'h4000 + XLEN'(k * 256));
        end
    endtask

    task automatic test_vl();
        cur_test = "vl_clamp";
        issue(op_setvl, 0, 0, 0, 32'd100);
        load_fresh(6, 32'h5000);
        store_and_check(6, 32'h5800);
        cur_test = "vl_short";
        issue(op_setvl, 0, 0, 0, 32'd3);
        load_fresh(6, 32'h5100);
        store_and_check(6, 32'h6000);
        issue(op_setvl, 0, 0, 0, VLMAX);
        // tail elements still hold the first load
        store_and_check(6, 32'h6100);
        cur_test = "vl_zero";
        issue(op_setvl, 0, 0, 0, 32'd0);
        load_fresh(6, 32'h5200);
        store_and_check(6, 32'h7000);
        issue(op_setvl, 0, 0, 0, VLMAX);
        store_and_check(6, 32'h7100);
    endtask

    // dependent chain with valid held high between instructions
    task automatic test_backpressure();
        vec_op_e         p_op  [7];
        int              p_vd  [7];
        int              p_vs1 [7];
        int              p_vs2 [7];
        logic [XLEN-1:0] p_rs1 [7];
        int              accepts0;
        int              count0;
        int              guard;
        p_op  = '{op_setvl, op_load, op_load, op_add, op_xor, op_sub, op_store};
        p_vd  = '{0, 8, 9, 10, 11, 12, 0};
        p_vs1 = '{0, 0, 0, 8, 10, 11, 12};
        p_vs2 = '{0, 0, 0, 9, 8, 9, 0};
        p_rs1 = '{VLMAX, 32'h8000, 32'h8100, 0, 0, 0, 32'ha000};
        cur_test = "backpressure";
        fill_random(32'h8000);
        fill_random(32'h8100);
        win_lo   = 32'ha000;
        win_hi   = 32'ha000 + XLEN'(VLMAX * ELEM_BYTES);
        accepts0 = accept_count;
        count0   = store_count;
        for (int k = 0; k < 7; k++) begin
            insn       = make_insn(p_op[k], p_vd[k], p_vs1[k], p_vs2[k]);
            rs1        = p_rs1[k];
            insn_valid = 1'b1;
            guard      = 0;
            while (!insn_ready && guard < WAIT_LIMIT) begin
                @(negedge clk_r);
                guard++;
            end
            @(posedge clk_r);
            @(negedge clk_r);
            assert (insn_ready === 1'b0) else begin
                $display("insn_ready still high right after accepting %s", p_op[k].name());
                other_errors++;
            end
        end
        insn_valid = 1'b0;
        guard      = 0;
        while (!insn_ready && guard < WAIT_LIMIT) begin
            @(negedge clk_r);
            guard++;
        end
        check_value("accepted instructions", 64'd7, 64'(accept_count - accepts0));
        for (int k = 0; k < 7; k++) begin
            apply_model(p_op[k], p_vd[k], p_vs1[k], p_vs2[k], p_rs1[k]);
        end
        check_store(12, 32'ha000, count0);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        reset        = 1'b1;
        insn         = '0;
        rs1          = '0;
        insn_valid   = 1'b0;
        vl_cur       = VLMAX;
        value_errors = 0;
        other_errors = 0;
        cur_test     = "init";
        repeat (10) @(negedge clk_r);
        reset = 1'b0;
        @(negedge clk_r);
        test_reset();
        test_round_trip();
        test_alu();
        test_vl();
        test_backpressure();
        @(negedge clk_r);
        $display("value errors: %0d, other errors: %0d, monitor errors: %0d",
                 value_errors, other_errors, monitor_errors);
        if (value_errors + other_errors + monitor_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/vec_pkg.sv
logic/vec_sequencer.sv
logic/vec_agu.sv
logic/vec_regfile.sv
logic/vec_exec.sv
logic/vec_unit_top.sv
tests/tb_vec_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vec_unit
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert -sv

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
